//--- hw/fpMulPkg.sv
`default_nettype none

package fpMulPkg;

	// IEEE single-precision word and its fields
	typedef logic [31:0] floatT;
	typedef logic [7:0] expT;
	typedef logic [23:0] mantT;         // Hidden bit included

	// Multiplier datapath
	typedef logic [47:0] prodT;
	typedef logic [48:0] sumT;          // Product plus carry out
	typedef logic signed [9:0] wideExpT;

	// Joint class of an operand pair, decided before the multiply
	typedef enum logic [1:0] {
		ClsNormal,
		ClsZero,
		ClsInf,
		ClsNan
	} opClassT;

	localparam int MantBits = 24;       // Shift-and-add step count
	localparam int ExpBias = 127;

	localparam expT ExpMax = 8'hff;     // Exponent field of inf and NaN
	localparam floatT QuietNan = 32'h7fc00000;

endpackage

`default_nettype wire

//--- hw/rippleCarryAdder.sv
`timescale 1ns/10ps
`default_nettype none

module rippleCarryAdder #(
	parameter int Width = 48
) (
	input  logic [Width-1:0] a,
	input  logic [Width-1:0] b,
	output logic [Width:0]   sum
);

	logic [Width-1:0] carry;

	// One cell per bit, carry ripples upward
	for (genvar i = 0; i < Width; i++) begin : gCell
		if (i == 0) begin : gHalf
			assign sum[i] = a[i] ^ b[i];
			assign carry[i] = a[i] & b[i];
		end else begin : gFull
			assign sum[i] = a[i] ^ b[i] ^ carry[i-1];
			assign carry[i] = (a[i] & b[i]) | (carry[i-1] & (a[i] ^ b[i]));
		end
	end

	assign sum[Width] = carry[Width-1];   // Final carry is the top sum bit

endmodule

`default_nettype wire

//--- hw/operandUnpack.sv
`timescale 1ns/10ps
`default_nettype none

module operandUnpack #(
	parameter int FifoDepth = 4
) (
	input  logic              clk,
	input  logic              arstN,
	input  logic              opValid,
	input  fpMulPkg::floatT   opA,
	input  fpMulPkg::floatT   opB,
	output logic              opReady,
	input  logic              creditReturn,
	output logic              pushValid,
	output logic              pushSign,
	output fpMulPkg::wideExpT pushExp,
	output fpMulPkg::mantT    pushMantA,
	output fpMulPkg::mantT    pushMantB,
	output fpMulPkg::opClassT pushClass
);
	import fpMulPkg::*;

	localparam int CntW = $clog2(FifoDepth + 1);

	logic [CntW-1:0] creditCnt;
	logic accept;
	expT expA;
	expT expB;
	logic anyNan;
	logic anyInf;
	logic anyZero;

	assign expA = opA[30:23];
	assign expB = opB[30:23];

	assign anyNan = (expA == ExpMax && opA[22:0] != '0) ||
		(expB == ExpMax && opB[22:0] != '0);
	assign anyInf = (expA == ExpMax && opA[22:0] == '0) ||
		(expB == ExpMax && opB[22:0] == '0);
	assign anyZero = expA == '0 || expB == '0;   // Subnormals count as zero

	// Output register holds a push for one cycle only
	assign opReady = creditCnt != '0 && !pushValid;
	assign accept = opValid && opReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pushValid <= 1'b0;
			creditCnt <= CntW'(FifoDepth);
		end else begin
			pushValid <= accept;
			creditCnt <= creditCnt + CntW'(creditReturn) - CntW'(pushValid);
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pushSign <= opA[31] ^ opB[31];
			pushExp <= wideExpT'(expA) + wideExpT'(expB) - wideExpT'(2 * ExpBias);
			pushMantA <= {expA != '0, opA[22:0]};
			pushMantB <= {expB != '0, opB[22:0]};
			if (anyNan || (anyInf && anyZero))
				pushClass <= ClsNan;
			else if (anyInf)
				pushClass <= ClsInf;
			else if (anyZero)
				pushClass <= ClsZero;
			else
				pushClass <= ClsNormal;
		end
	end

	creditBound: assert property (@(posedge clk) disable iff (!arstN)
		creditCnt <= CntW'(FifoDepth))
		else $error("Producer credit count above buffer depth");

	pushHasCredit: assert property (@(posedge clk) disable iff (!arstN)
		pushValid |-> creditCnt != '0)
		else $error("Push issued with no credit left");

endmodule

`default_nettype wire

//--- hw/operandFifo.sv
`timescale 1ns/10ps
`default_nettype none

module operandFifo #(
	parameter int FifoDepth = 4
) (
	input  logic              clk,
	input  logic              arstN,
	input  logic              pushValid,
	input  logic              pushSign,
	input  fpMulPkg::wideExpT pushExp,
	input  fpMulPkg::mantT    pushMantA,
	input  fpMulPkg::mantT    pushMantB,
	input  fpMulPkg::opClassT pushClass,
	output logic              fifoValid,
	output logic              fifoSign,
	output fpMulPkg::wideExpT fifoExp,
	output fpMulPkg::mantT    fifoMantA,
	output fpMulPkg::mantT    fifoMantB,
	output fpMulPkg::opClassT fifoClass,
	input  logic              popReady,
	output logic              creditReturn
);
	import fpMulPkg::*;

	localparam int PtrW = FifoDepth > 1 ? $clog2(FifoDepth) : 1;
	localparam int CntW = $clog2(FifoDepth + 1);

	logic signMem [FifoDepth];
	wideExpT expMem [FifoDepth];
	mantT mantAMem [FifoDepth];
	mantT mantBMem [FifoDepth];
	opClassT classMem [FifoDepth];

	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count;
	logic pop;

	// Wraps for depths that are not a power of two
	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] p);
		return (p == PtrW'(FifoDepth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign fifoValid = count != '0;
	assign pop = fifoValid && popReady;

	assign fifoSign = signMem[rdPtr];
	assign fifoExp = expMem[rdPtr];
	assign fifoMantA = mantAMem[rdPtr];
	assign fifoMantB = mantBMem[rdPtr];
	assign fifoClass = classMem[rdPtr];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end else begin
			if (pushValid)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			count <= count + CntW'(pushValid) - CntW'(pop);
			creditReturn <= pop;   // One credit back per pop
		end
	end

	always_ff @(posedge clk) begin
		if (pushValid) begin
			signMem[wrPtr] <= pushSign;
			expMem[wrPtr] <= pushExp;
			mantAMem[wrPtr] <= pushMantA;
			mantBMem[wrPtr] <= pushMantB;
			classMem[wrPtr] <= pushClass;
		end
	end

	// Full buffer on a push means the producer overspent its credits
	noPushWhenFull: assert property (@(posedge clk) disable iff (!arstN)
		pushValid |-> count != CntW'(FifoDepth))
		else $error("Push into a full operand buffer");

endmodule

`default_nettype wire

//--- hw/mantissaMultiplier.sv
`timescale 1ns/10ps
`default_nettype none

module mantissaMultiplier (
	input  logic              clk,
	input  logic              arstN,
	input  logic              fifoValid,
	input  logic              fifoSign,
	input  fpMulPkg::wideExpT fifoExp,
	input  fpMulPkg::mantT    fifoMantA,
	input  fpMulPkg::mantT    fifoMantB,
	input  fpMulPkg::opClassT fifoClass,
	output logic              popReady,
	input  logic              rndReady,
	output logic              prodValid,
	output fpMulPkg::prodT    prod,
	output logic              prodSign,
	output fpMulPkg::wideExpT prodExp,
	output fpMulPkg::opClassT prodClass
);
	import fpMulPkg::*;

	localparam int StepW = $clog2(MantBits);
	localparam int ProdW = $bits(prodT);

	typedef enum logic [1:0] {
		Idle,
		Run,
		Done
	} stateT;

	stateT state;
	logic [StepW-1:0] stepCnt;
	prodT mcand;          // Multiplicand shifted left each step
	mantT mplier;         // Multiplier shifted right each step
	prodT addend;
	sumT addSum;
	logic pop;

	assign popReady = state == Idle && rndReady;
	assign pop = fifoValid && popReady;

	assign addend = mplier[0] ? mcand : '0;

	rippleCarryAdder #(
		.Width(ProdW)
	) uAdder (
		.a(prod),
		.b(addend),
		.sum(addSum)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= Idle;
			stepCnt <= '0;
			prodValid <= 1'b0;
		end else begin
			prodValid <= 1'b0;
			case (state)
				Idle: begin
					if (pop) begin
						state <= Run;
						stepCnt <= '0;
					end
				end
				Run: begin
					stepCnt <= stepCnt + 1'b1;
					if (stepCnt == StepW'(MantBits - 1))
						state <= Done;
				end
				Done: begin
					prodValid <= 1'b1;
					state <= Idle;
				end
				default: state <= Idle;
			endcase
		end
	end

	// Accumulator doubles as the product output
	always_ff @(posedge clk) begin
		if (pop) begin
			mcand <= ProdW'(fifoMantA);
			mplier <= fifoMantB;
			prod <= '0;
			prodSign <= fifoSign;
			prodExp <= fifoExp;
			prodClass <= fifoClass;
		end else if (state == Run) begin
			prod <= addSum[ProdW-1:0];
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	// Rounder holds back rndReady while a product is handed over
	popOnlyIdle: assert property (@(posedge clk) disable iff (!arstN)
		popReady |-> state == Idle && !prodValid)
		else $error("Pop offered outside idle");

endmodule

`default_nettype wire

//--- hw/normalizeRound.sv
`timescale 1ns/10ps
`default_nettype none

module normalizeRound #(
	parameter int ResCredits = 2
) (
	input  logic              clk,
	input  logic              arstN,
	input  logic              prodValid,
	input  fpMulPkg::prodT    prod,
	input  logic              prodSign,
	input  fpMulPkg::wideExpT prodExp,
	input  fpMulPkg::opClassT prodClass,
	output logic              rndReady,
	output logic              resValid,
	output fpMulPkg::floatT   res,
	input  logic              resCredit
);
	import fpMulPkg::*;

	localparam int CntW = $clog2(ResCredits + 1);

	logic [CntW-1:0] creditCnt;
	logic normShift;
	mantT mantTrunc;
	logic guardBit;
	logic stickyBit;
	logic roundUp;
	logic [MantBits:0] mantRnd;
	wideExpT expBiased;
	logic expOver;
	logic expUnder;
	floatT resNext;

	always_comb begin
		normShift = prod[47];   // Product in [2,4)
		if (normShift) begin
			mantTrunc = prod[47:24];
			guardBit = prod[23];
			stickyBit = |prod[22:0];
		end else begin
			mantTrunc = prod[46:23];
			guardBit = prod[22];
			stickyBit = |prod[21:0];
		end

		// Nearest even, a carry leaves the fraction at zero
		roundUp = guardBit && (stickyBit || mantTrunc[0]);
		mantRnd = {1'b0, mantTrunc} + {{MantBits{1'b0}}, roundUp};

		expBiased = prodExp + wideExpT'(ExpBias) + wideExpT'(normShift) +
			wideExpT'(mantRnd[MantBits]);
		expOver = expBiased >= wideExpT'(ExpMax);
		expUnder = expBiased <= wideExpT'(0);

		if (prodClass == ClsNan)
			resNext = QuietNan;
		else if (prodClass == ClsInf || (prodClass == ClsNormal && expOver))
			resNext = {prodSign, ExpMax, 23'd0};
		else if (prodClass == ClsZero || expUnder)
			resNext = {prodSign, 31'd0};   // Flush to signed zero
		else
			resNext = {prodSign, expT'(expBiased), mantRnd[MantBits-2:0]};
	end

	// A product arriving now spends the credit it was popped against
	assign rndReady = creditCnt != '0 && !prodValid;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resValid <= 1'b0;
			creditCnt <= CntW'(ResCredits);
		end else begin
			resValid <= prodValid;
			creditCnt <= creditCnt + CntW'(resCredit) - CntW'(prodValid);
		end
	end

	always_ff @(posedge clk) begin
		if (prodValid)
			res <= resNext;
	end

	creditBound: assert property (@(posedge clk) disable iff (!arstN)
		creditCnt <= CntW'(ResCredits))
		else $error("Sink returned more credits than granted");

	// Multiplier pops only with a credit in hand
	prodHasCredit: assert property (@(posedge clk) disable iff (!arstN)
		prodValid |-> creditCnt != '0)
		else $error("Product arrived with no downstream credit");

endmodule

`default_nettype wire

//--- hw/fpMulTop.sv
`timescale 1ns/10ps
`default_nettype none

module fpMulTop #(
	parameter int FifoDepth = 4,
	parameter int ResCredits = 2
) (
	input  logic            clk,
	input  logic            arstN,
	input  logic            opValid,
	input  fpMulPkg::floatT opA,
	input  fpMulPkg::floatT opB,
	output logic            opReady,
	output logic            resValid,
	output fpMulPkg::floatT res,
	input  logic            resCredit
);
	import fpMulPkg::*;

	// Producer to buffer
	logic pushValid;
	logic pushSign;
	wideExpT pushExp;
	mantT pushMantA;
	mantT pushMantB;
	opClassT pushClass;
	logic creditReturn;

	// Buffer head
	logic fifoValid;
	logic fifoSign;
	wideExpT fifoExp;
	mantT fifoMantA;
	mantT fifoMantB;
	opClassT fifoClass;
	logic popReady;

	// Multiplier to rounder
	logic rndReady;
	logic prodValid;
	prodT prod;
	logic prodSign;
	wideExpT prodExp;
	opClassT prodClass;

	operandUnpack #(
		.FifoDepth(FifoDepth)
	) uUnpack (
		.clk(clk),
		.arstN(arstN),
		.opValid(opValid),
		.opA(opA),
		.opB(opB),
		.opReady(opReady),
		.creditReturn(creditReturn),
		.pushValid(pushValid),
		.pushSign(pushSign),
		.pushExp(pushExp),
		.pushMantA(pushMantA),
		.pushMantB(pushMantB),
		.pushClass(pushClass)
	);

	operandFifo #(
		.FifoDepth(FifoDepth)
	) uFifo (
		.clk(clk),
		.arstN(arstN),
		.pushValid(pushValid),
		.pushSign(pushSign),
		.pushExp(pushExp),
		.pushMantA(pushMantA),
		.pushMantB(pushMantB),
		.pushClass(pushClass),
		.fifoValid(fifoValid),
		.fifoSign(fifoSign),
		.fifoExp(fifoExp),
		.fifoMantA(fifoMantA),
		.fifoMantB(fifoMantB),
		.fifoClass(fifoClass),
		.popReady(popReady),
		.creditReturn(creditReturn)
	);

	mantissaMultiplier uMult (
		.clk(clk),
		.arstN(arstN),
		.fifoValid(fifoValid),
		.fifoSign(fifoSign),
		.fifoExp(fifoExp),
		.fifoMantA(fifoMantA),
		.fifoMantB(fifoMantB),
		.fifoClass(fifoClass),
		.popReady(popReady),
		.rndReady(rndReady),
		.prodValid(prodValid),
		.prod(prod),
		.prodSign(prodSign),
		.prodExp(prodExp),
		.prodClass(prodClass)
	);

	normalizeRound #(
		.ResCredits(ResCredits)
	) uRound (
		.clk(clk),
		.arstN(arstN),
		.prodValid(prodValid),
		.prod(prod),
		.prodSign(prodSign),
		.prodExp(prodExp),
		.prodClass(prodClass),
		.rndReady(rndReady),
		.resValid(resValid),
		.res(res),
		.resCredit(resCredit)
	);

endmodule

`default_nettype wire

//--- dv/fpMulChecker.sv
`timescale 1ns/10ps
`default_nettype none

module fpMulChecker #(
	parameter int ResCredits = 2
) (
	input  logic        clk,
	input  logic        arstN,
	input  logic        opValid,
	input  logic        opReady,
	input  logic [31:0] opA,
	input  logic [31:0] opB,
	input  logic        resValid,
	input  logic [31:0] res,
	input  logic        resCredit,
	input  logic        endOfTest,
	output int          errCount,
	output logic        reportDone
);

	localparam logic [31:0] QuietNanWord = 32'h7fc00000;
	localparam int IdleLatency = 28;   // Edges from acceptance to resValid

	logic [31:0] expQ [$];
	int acceptQ [$];
	logic timedQ [$];

	int edgeCnt = 0;
	int sinkCredits = ResCredits;
	int acceptCount = 0;
	int resCount = 0;
	int timedCount = 0;
	int lowRun = 0;
	int maxLowRun = 0;
	int valueErrs = 0;
	int protoErrs = 0;

	assign errCount = valueErrs + protoErrs;

	// fp32 multiply with subnormals as zero, nearest even, flush on underflow
	function automatic logic [31:0] refMul(input logic [31:0] a, input logic [31:0] b);
		logic s;
		logic nanIn;
		logic infIn;
		logic zeroIn;
		logic [47:0] mA;
		logic [47:0] mB;
		logic [47:0] p;
		logic [24:0] m;
		logic g;
		logic st;
		int e;
		s = a[31] ^ b[31];
		nanIn = (a[30:23] == 8'hff && a[22:0] != 0) || (b[30:23] == 8'hff && b[22:0] != 0);
		infIn = (a[30:23] == 8'hff && a[22:0] == 0) || (b[30:23] == 8'hff && b[22:0] == 0);
		zeroIn = a[30:23] == 8'h00 || b[30:23] == 8'h00;
		if (nanIn || (infIn && zeroIn))
			return QuietNanWord;
		if (infIn)
			return {s, 8'hff, 23'd0};
		if (zeroIn)
			return {s, 31'd0};
		mA = {24'd0, 1'b1, a[22:0]};
		mB = {24'd0, 1'b1, b[22:0]};
		p = mA * mB;
		e = int'(a[30:23]) + int'(b[30:23]) - 127;
		if (p[47]) begin
			e = e + 1;
			m = {1'b0, p[47:24]};
			g = p[23];
			st = |p[22:0];
		end else begin
			m = {1'b0, p[46:23]};
			g = p[22];
			st = |p[21:0];
		end
		if (g && (st || m[0]))
			m = m + 25'd1;
		if (m[24]) begin   // Rounded up to 2.0
			e = e + 1;
			m = m >> 1;
		end
		if (e >= 255)
			return {s, 8'hff, 23'd0};
		if (e <= 0)
			return {s, 31'd0};
		return {s, 8'(e), m[22:0]};
	endfunction

	task automatic protoError(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		protoErrs++;
	endtask

	always @(posedge clk) begin : watch
		logic [31:0] expVal;
		int stamp;
		logic timed;
		if (arstN) begin
			edgeCnt++;
			lowRun = opReady ? 0 : lowRun + 1;
			if (lowRun > maxLowRun)
				maxLowRun = lowRun;
			if (resValid) begin
				resCount++;
				if (sinkCredits == 0)
					protoError("result issued with no downstream credit");
				else
					sinkCredits--;
				if (expQ.size() == 0) begin
					protoError("result arrived with no pair waiting for it");
				end else begin
					expVal = expQ.pop_front();
					stamp = acceptQ.pop_front();
					timed = timedQ.pop_front();
					if (res !== expVal) begin
						$display("CHECK FAILED at %0t: res expected %h actual %h",
							$time, expVal, res);
						valueErrs++;
					end
					// resValid was set one edge before this sample
					if (timed) begin
						timedCount++;
						if (edgeCnt - 1 - stamp != IdleLatency)
							protoError($sformatf("idle latency was %0d edges instead of %0d",
								edgeCnt - 1 - stamp, IdleLatency));
					end
				end
			end
			if (resCredit) begin
				sinkCredits++;
				if (sinkCredits > ResCredits)
					protoError("sink returned more credits than results received");
			end
			if (opValid && opReady) begin
				acceptCount++;
				timedQ.push_back(expQ.size() == 0 && sinkCredits > 0);
				expQ.push_back(refMul(opA, opB));
				acceptQ.push_back(edgeCnt);
			end
		end
	end

	initial begin
		reportDone = 1'b0;
		wait (endOfTest);
		if (expQ.size() != 0)
			protoError($sformatf("%0d accepted pairs never produced a result", expQ.size()));
		if (maxLowRun < 2)
			protoError("opReady never stayed low while the sink withheld credits");
		if (timedCount == 0)
			protoError("no operation was timed on an idle pipeline");
		$display("Results %0d of %0d accepted, value errors %0d, protocol errors %0d",
			resCount, acceptCount, valueErrs, protoErrs);
		reportDone = 1'b1;
	end

endmodule

`default_nettype wire

//--- dv/fpMulTb.sv
`timescale 1ns/10ps
`default_nettype none

module fpMulTb;
	import fpMulPkg::*;

	localparam int ClkPeriod = 100;
	localparam int FifoDepth = 4;
	localparam int ResCredits = 2;
	localparam int DirOps = 22;
	localparam int RandOps = 200;
	localparam int StallOps = 40;
	localparam int NumOps = DirOps + RandOps + StallOps + 1;
	localparam int WatchdogCycles = NumOps * 40 + 2000;

	logic clk;
	logic arstN;
	logic opValid;
	floatT opA;
	floatT opB;
	logic opReady;
	logic resValid;
	floatT res;
	logic resCredit;
	logic endOfTest;
	logic reportDone;
	int errCount;

	logic [31:0] lfsrState = 32'h0ea0f081;
	logic stallMode;
	int sentCount = 0;
	int rcvCount = 0;
	int owed = 0;        // Results whose credit is not yet returned

	fpMulTop #(
		.FifoDepth(FifoDepth),
		.ResCredits(ResCredits)
	) u_dut (
		.clk(clk),
		.arstN(arstN),
		.opValid(opValid),
		.opA(opA),
		.opB(opB),
		.opReady(opReady),
		.resValid(resValid),
		.res(res),
		.resCredit(resCredit)
	);

	fpMulChecker #(
		.ResCredits(ResCredits)
	) uCheck (
		.clk(clk),
		.arstN(arstN),
		.opValid(opValid),
		.opReady(opReady),
		.opA(opA),
		.opB(opB),
		.resValid(resValid),
		.res(res),
		.resCredit(resCredit),
		.endOfTest(endOfTest),
		.errCount(errCount),
		.reportDone(reportDone)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	function automatic floatT randOperand();
		logic [3:0] kind;
		logic sign;
		logic [7:0] e;
		logic [22:0] frac;
		kind = 4'(randBits(4));
		sign = 1'(randBits(1));
		frac = 23'(randBits(23));
		if (kind < 4'd11)
			e = 8'd96 + 8'(randBits(6));   // Mostly in range
		else if (kind < 4'd13)
			e = 8'(randBits(8));           // Reaches overflow and underflow
		else if (kind == 4'd13)
			e = 8'd0;                      // Zero or subnormal
		else if (kind == 4'd14) begin
			e = 8'hff;
			frac = 23'd0;
		end else begin
			e = 8'hff;
			frac = frac | 23'd1;
		end
		return {sign, e, frac};
	endfunction

	// Called and returns 10 ns after a rising edge
	task automatic sendOp(input floatT a, input floatT b);
		opA = a;
		opB = b;
		opValid = 1'b1;
		do
			@(posedge clk);
		while (!opReady);
		#10;
		opValid = 1'b0;
		sentCount++;
	endtask

	task automatic waitDrained();
		do
			@(negedge clk);
		while (rcvCount != sentCount || owed != 0);
		@(posedge clk);
		#10;
	endtask

	task automatic runDirected();
		sendOp(32'h3f800001, 32'h3fc00000);   // Tie, odd mantissa rounds up
		sendOp(32'h3f800003, 32'h3fc00000);   // Tie, even mantissa stays
		sendOp(32'hbf800001, 32'h3fc00000);
		sendOp(32'h3f800001, 32'h3ffffffe);   // Round carry bumps exponent
		sendOp(32'h3fc00000, 32'h3fc00000);   // Product of 2.25
		sendOp(32'h3fffffff, 32'h3fffffff);
		sendOp(32'h40400000, 32'hc0a00000);
		sendOp(32'h00000000, 32'h40a00000);
		sendOp(32'h80000000, 32'h40400000);
		sendOp(32'h7f800000, 32'h40000000);
		sendOp(32'hff800000, 32'h40400000);
		sendOp(32'h7f800000, 32'h00000000);   // Inf times zero
		sendOp(32'h80000000, 32'hff800000);
		sendOp(32'h7f800001, 32'h3f800000);
		sendOp(32'h3f800000, 32'hffc12345);
		sendOp(32'h00000001, 32'h40000000);   // Subnormal as zero
		sendOp(32'h807fffff, 32'h7f800000);
		sendOp(32'h7f000000, 32'h7f000000);   // Overflow
		sendOp(32'hff000000, 32'h7f000000);
		sendOp(32'h00800000, 32'h80800000);   // Underflow
		sendOp(32'h1f800000, 32'h1f800000);
		sendOp(32'h7f7fffff, 32'h3f800001);   // Normalize shift overflows
	endtask

	task automatic runRandom(input int count, input int gapBits);
		floatT a;
		floatT b;
		int gap;
		for (int i = 0; i < count; i++) begin
			a = randOperand();
			b = randOperand();
			sendOp(a, b);
			gap = randBits(gapBits);
			repeat (gap) begin
				@(posedge clk);
				#10;
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// Sink returns one credit per result after a random delay
	initial begin : sink
		int holdLeft;
		logic takeDelay;
		holdLeft = 0;
		takeDelay = 1'b0;
		forever begin
			@(posedge clk);
			if (resValid) begin
				rcvCount++;
				owed++;
			end
			#10;
			resCredit = 1'b0;
			if (holdLeft != 0)
				holdLeft--;
			else if (owed != 0) begin
				resCredit = 1'b1;
				owed--;
				takeDelay = 1'b1;
			end
			#20;   // Away from the stimulus draws
			if (takeDelay) begin
				holdLeft = stallMode ? randBits(6) : randBits(2);
				takeDelay = 1'b0;
			end
		end
	end

	initial begin
		#(WatchdogCycles * ClkPeriod);
		$display("Timeout after %0d cycles, the pipeline stopped making progress",
			WatchdogCycles);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		arstN = 1'b0;
		opValid = 1'b0;
		opA = '0;
		opB = '0;
		resCredit = 1'b0;
		stallMode = 1'b0;
		endOfTest = 1'b0;
		repeat (3) @(posedge clk);
		#10;
		arstN = 1'b1;

		runDirected();
		runRandom(RandOps, 2);
		stallMode = 1'b1;          // Long credit stalls fill the pipeline
		runRandom(StallOps, 0);
		stallMode = 1'b0;
		waitDrained();
		sendOp(32'h40490fdb, 32'hc02df854);   // Timed on an idle pipeline
		waitDrained();

		endOfTest = 1'b1;
		wait (reportDone);
		if (errCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
hw/fpMulPkg.sv
hw/rippleCarryAdder.sv
hw/operandUnpack.sv
hw/operandFifo.sv
hw/mantissaMultiplier.sv
hw/normalizeRound.sv
hw/fpMulTop.sv
dv/fpMulChecker.sv
dv/fpMulTb.sv

//--- Makefile
TOP := fpMulTb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
